// File: tests/read_patterns.hex
// 256 memory words, one 32-bit word per entry, then request records
// Request columns: byte address, byte length, credit gap in cycles; zero length ends the list
004080c0 014181c1 024282c2 034383c3 044484c4 054585c5 064686c6 074787c7 084888c8 094989c9
0a4a8aca 0b4b8bcb 0c4c8ccc 0d4d8dcd 0e4e8ece 0f4f8fcf 105090d0 115191d1 125292d2 135393d3
145494d4 155595d5 165696d6 175797d7 185898d8 195999d9 1a5a9ada 1b5b9bdb 1c5c9cdc 1d5d9ddd
1e5e9ede 1f5f9fdf 2060a0e0 2161a1e1 2262a2e2 2363a3e3 2464a4e4 2565a5e5 2666a6e6 2767a7e7
2868a8e8 2969a9e9 2a6aaaea 2b6babeb 2c6cacec 2d6daded 2e6eaeee 2f6fafef 3070b0f0 3171b1f1
3272b2f2 3373b3f3 3474b4f4 3575b5f5 3676b6f6 3777b7f7 3878b8f8 3979b9f9 3a7abafa 3b7bbbfb
3c7cbcfc 3d7dbdfd 3e7ebefe 3f7fbfff 4080c000 4181c101 4282c202 4383c303 4484c404 4585c505
4686c606 4787c707 4888c808 4989c909 4a8aca0a 4b8bcb0b 4c8ccc0c 4d8dcd0d 4e8ece0e 4f8fcf0f
5090d010 5191d111 5292d212 5393d313 5494d414 5595d515 5696d616 5797d717 5898d818 5999d919
5a9ada1a 5b9bdb1b 5c9cdc1c 5d9ddd1d 5e9ede1e 5f9fdf1f 60a0e020 61a1e121 62a2e222 63a3e323
64a4e424 65a5e525 66a6e626 67a7e727 68a8e828 69a9e929 6aaaea2a 6babeb2b 6cacec2c 6daded2d
6eaeee2e 6fafef2f 70b0f030 71b1f131 72b2f232 73b3f333 74b4f434 75b5f535 76b6f636 77b7f737
78b8f838 79b9f939 7abafa3a 7bbbfb3b 7cbcfc3c 7dbdfd3d 7ebefe3e 7fbfff3f 80c00040 81c10141
82c20242 83c30343 84c40444 85c50545 86c60646 87c70747 88c80848 89c90949 8aca0a4a 8bcb0b4b
8ccc0c4c 8dcd0d4d 8ece0e4e 8fcf0f4f 90d01050 91d11151 92d21252 93d31353 94d41454 95d51555
96d61656 97d71757 98d81858 99d91959 9ada1a5a 9bdb1b5b 9cdc1c5c 9ddd1d5d 9ede1e5e 9fdf1f5f
a0e02060 a1e12161 a2e22262 a3e32363 a4e42464 a5e52565 a6e62666 a7e72767 a8e82868 a9e92969
aaea2a6a abeb2b6b acec2c6c aded2d6d aeee2e6e afef2f6f b0f03070 b1f13171 b2f23272 b3f33373
b4f43474 b5f53575 b6f63676 b7f73777 b8f83878 b9f93979 bafa3a7a bbfb3b7b bcfc3c7c bdfd3d7d
befe3e7e bfff3f7f c0004080 c1014181 c2024282 c3034383 c4044484 c5054585 c6064686 c7074787
c8084888 c9094989 ca0a4a8a cb0b4b8b cc0c4c8c cd0d4d8d ce0e4e8e cf0f4f8f d0105090 d1115191
d2125292 d3135393 d4145494 d5155595 d6165696 d7175797 d8185898 d9195999 da1a5a9a db1b5b9b
dc1c5c9c dd1d5d9d de1e5e9e df1f5f9f e02060a0 e12161a1 e22262a2 e32363a3 e42464a4 e52565a5
e62666a6 e72767a7 e82868a8 e92969a9 ea2a6aaa eb2b6bab ec2c6cac ed2d6dad ee2e6eae ef2f6faf
f03070b0 f13171b1 f23272b2 f33373b3 f43474b4 f53575b5 f63676b6 f73777b7 f83878b8 f93979b9
fa3a7aba fb3b7bbb fc3c7cbc fd3d7dbd fe3e7ebe ff3f7fbf
00000000 00000040 00000001
00000013 00000025 00000002
00000fe6 00000046 00000003
00000102 00000005 00000000
000003f1 00000001 00000004
00000000 00000000 00000000

// File: sources.f
logic/axi_pkg.sv
logic/dma_pkg.sv
logic/burst_planner.sv
logic/burst_align.sv
logic/axi_read_adapter.sv
logic/read_engine_top.sv
tests/read_checker.sv
tests/read_tb.sv

// File: tests/read_tb.sv
module read_tb
  import axi_pkg::*, dma_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk = 1'b0;
  logic        rst;
  logic        req_valid;
  dma_req_t    req;
  logic        req_accept;
  logic        credit_return;
  logic        out_valid;
  dma_word_t   out;
  axi_ar_t     ar;
  logic        ar_valid;
  logic        ar_ready;
  axi_r_t      r;
  logic        r_valid;
  logic        r_ready;
  logic [31:0] pat [0:511];
  logic [31:0] lfsr_state;
  int          nreq;
  int          cur_req;
  int          cur_gap;
  int          gap_cnt;
  int          owed;     // Word slots freed by the consumer but not yet returned
  int          tb_errors;
  int          chk_errors;
  int          accepts;
  int          done_count;

  always #20 clk = ~clk;

  read_engine_top dut (.*);

  read_checker checker_i (
    .clk (clk), .rst (rst), .req_accept (req_accept), .req (req),
    .credit_return (credit_return), .out_valid (out_valid), .out (out),
    .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
    .r (r), .r_valid (r_valid), .r_ready (r_ready),
    .errors (chk_errors), .accepts (accepts), .done_count (done_count)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  // AXI slave memory model
  always begin : slave_model
    logic [31:0] a;
    int          beats;
    @(negedge clk);
    if (ar_valid && !rst) begin
      repeat (rand_bits(2)) @(negedge clk);
      ar_ready = 1'b1;
      a        = ar.addr;
      beats    = ar.len + 1;
      @(negedge clk);
      ar_ready = 1'b0;
      for (int k = 0; k < beats; k++) begin
        repeat (rand_bits(1)) @(negedge clk);
        r.data  = pat[a[9:2]] ^ {a[31:10], 10'b0}; // Image repeats every 1 KB
        r.last  = (k == beats - 1);
        r_valid = 1'b1;
        @(negedge clk);
        r_valid = 1'b0;
        a       = a + 4;
      end
    end
  end

  // Consumer frees one slot per word it takes
  always @(posedge clk) if (!rst && out_valid) owed = owed + 1;

  always @(negedge clk) begin
    credit_return = 1'b0;
    if (owed > 0) begin
      if (gap_cnt >= cur_gap) begin
        credit_return = 1'b1;
        owed          = owed - 1;
        gap_cnt       = 0;
      end else begin
        gap_cnt++;
      end
    end
  end

  initial begin
    rst = 1'b1;
    req_valid = 1'b0;
    req = '0;
    credit_return = 1'b0;
    ar_ready = 1'b0;
    r = '0;
    r_valid = 1'b0;
    owed = 0;
    gap_cnt = 0;
    cur_gap = 0;
    cur_req = 0;
    tb_errors = 0;
    lfsr_state = 32'h80ac_aca3;
    $readmemh("tests/read_patterns.hex", pat);
    nreq = 0;
    while (nreq < 80 && pat[256 + 3 * nreq + 1] != 0) nreq++;
    fork
      begin
        repeat (2000 * nreq + 100) @(posedge clk);
        $display("Timeout: request %0d of %0d did not finish", cur_req, nreq);
        $display("Finished with errors");
        $finish;
      end
    join_none
    repeat (5) @(posedge clk);
    @(negedge clk) rst = 1'b0;
    for (cur_req = 0; cur_req < nreq; cur_req++) begin
      @(negedge clk);
      req.addr      = pat[256 + 3 * cur_req];
      req.len_bytes = pat[256 + 3 * cur_req + 1][11:0];
      req_valid     = 1'b1;
      do @(posedge clk); while (!req_accept);
      cur_gap = pat[256 + 3 * cur_req + 2];
      @(negedge clk) req_valid = 1'b0;
      if (cur_req == 0) begin
        repeat (30) @(posedge clk); // Credits withheld, so no AR may appear
        owed = owed + 16;           // Consumer starts with 16 free slots
      end
      while (done_count < cur_req + 1) @(posedge clk);
      repeat (3) @(posedge clk);
    end
    if (accepts != nreq) begin
      tb_errors++;
      $display("Saw %0d request accepts for %0d requests", accepts, nreq);
    end
    $display("Closing report: %0d checker errors, %0d testbench errors", chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: tests/read_checker.sv
module read_checker
  import axi_pkg::*, dma_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      req_accept,
  input  dma_req_t  req,
  input  logic      credit_return,
  input  logic      out_valid,
  input  dma_word_t out,
  input  axi_ar_t   ar,
  input  logic      ar_valid,
  input  logic      ar_ready,
  input  axi_r_t    r,
  input  logic      r_valid,
  input  logic      r_ready,
  output int        errors,
  output int        accepts,
  output int        done_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] pat [0:511];
  logic [31:0] base_addr;
  logic [31:0] cov_next;   // Next address the bursts must start at
  logic [11:0] cur_len;
  logic [7:0]  exp_b;
  int          returned;
  int          words_out;
  int          word_idx;
  int          nwords;
  bit          in_req;
  bit          in_data;    // Between AR handshake and last R beat
  bit          prev_arv;

  initial begin
    errors     = 0;
    accepts    = 0;
    done_count = 0;
    returned   = 0;
    words_out  = 0;
    in_req     = 0;
    in_data    = 0;
    prev_arv   = 0;
    $readmemh("tests/read_patterns.hex", pat);
  end

  function automatic logic [7:0] mem_byte(input logic [31:0] a);
    logic [31:0] w;
    w = pat[a[9:2]] ^ {a[31:10], 10'b0}; // Image repeats every 1 KB, upper bits folded in
    return w[8*a[1:0] +: 8];
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (req_accept) begin
        accepts++;
        base_addr = req.addr;
        cur_len   = req.len_bytes;
        cov_next  = {req.addr[31:2], 2'b00};
        word_idx  = 0;
        in_req    = 1;
      end
      if (!in_req && (ar_valid || out_valid))
        report_mismatch("ar_valid or out_valid high outside a request");
      if (ar_valid && !prev_arv && (returned - words_out < ar.len + 1))
        report_mismatch($sformatf("AR issued with %0d credits for %0d beats",
                                  returned - words_out, ar.len + 1));
      if (r_ready !== in_data)
        report_mismatch($sformatf("r_ready is %b, expected %b", r_ready, in_data));
      if (ar_valid && ar_ready) begin
        // INCR bursts of full 4-byte beats
        if (ar.burst !== 2'b01 || ar.size !== 3'd2)
          report_mismatch("AR burst type or size wrong");
        if (ar.cache !== 4'b0001 || ar.prot[2] !== 1'b0)
          report_mismatch("AR cache or prot wrong");
        if (ar.len + 1 > 16)
          report_mismatch($sformatf("AR len %0d exceeds 16 beats", ar.len + 1));
        if (ar.addr[11:0] + (ar.len + 1) * 4 > 4096)
          report_mismatch($sformatf("AR at %h crosses 4 KB", ar.addr));
        if (ar.addr != cov_next)
          report_mismatch($sformatf("AR at %h, expected %h", ar.addr, cov_next));
        cov_next = ar.addr + (ar.len + 1) * 4;
        in_data  = 1;
      end
      if (r_valid && r_ready && r.last)
        in_data = 0;
      if (out_valid) begin
        words_out++;
        if (words_out > returned)
          report_mismatch("more words out than credits returned");
        for (int b = 0; b < 4; b++) begin
          if (word_idx * 4 + b < cur_len) begin
            exp_b = mem_byte(base_addr + word_idx * 4 + b);
            if (out.data[8*b +: 8] !== exp_b)
              report_mismatch($sformatf("word %0d byte %0d is %h, expected %h",
                                        word_idx, b, out.data[8*b +: 8], exp_b));
          end
        end
        nwords = (cur_len + 3) / 4;
        if (out.last != (word_idx == nwords - 1))
          report_mismatch($sformatf("last flag wrong on word %0d", word_idx));
        word_idx++;
        if (out.last) begin
          if (cov_next < base_addr + cur_len)
            report_mismatch("bursts do not cover the request");
          in_req = 0;
          done_count++;
        end
      end
      returned += credit_return;
      prev_arv = ar_valid;
    end
  end

endmodule

// File: logic/read_engine_top.sv
module read_engine_top
  import axi_pkg::*, dma_pkg::*;
#(
  parameter int ADDR_W    = AXI_ADDR_W, // Must match the struct widths
  parameter int DATA_W    = AXI_DATA_W,
  parameter int LEN_W     = DMA_LEN_W,
  parameter int MAX_BEATS = 16,
  parameter int CREDIT_W  = 6
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid,
  input  dma_req_t  req,
  output logic      req_accept,
  input  logic      credit_return,
  output logic      out_valid,
  output dma_word_t out,
  output axi_ar_t   ar,
  output logic      ar_valid,
  input  logic      ar_ready,
  input  axi_r_t    r,
  input  logic      r_valid,
  output logic      r_ready
);

  axi_read_adapter #(
    .ADDR_W    (ADDR_W),
    .DATA_W    (DATA_W),
    .LEN_W     (LEN_W),
    .MAX_BEATS (MAX_BEATS),
    .CREDIT_W  (CREDIT_W)
  ) adapter_i (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req           (req),
    .req_accept    (req_accept),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out           (out),
    .ar            (ar),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .r             (r),
    .r_valid       (r_valid),
    .r_ready       (r_ready)
  );

endmodule

// File: logic/axi_read_adapter.sv
module axi_read_adapter
  import axi_pkg::*, dma_pkg::*;
#(
  parameter int ADDR_W    = AXI_ADDR_W,
  parameter int DATA_W    = AXI_DATA_W,
  parameter int LEN_W     = 12,
  parameter int MAX_BEATS = 16,
  parameter int CREDIT_W  = 6
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid,
  input  dma_req_t  req,
  output logic      req_accept,
  input  logic      credit_return,
  output logic      out_valid,
  output dma_word_t out,
  output axi_ar_t   ar,
  output logic      ar_valid,
  input  logic      ar_ready,
  input  axi_r_t    r,
  input  logic      r_valid,
  output logic      r_ready
);

  localparam int OFF_W  = offset_w_of(DATA_W);
  localparam int BEAT_W = beat_w_of(MAX_BEATS);
  localparam int BYTES  = DATA_W / 8;
  localparam int CNT_W  = LEN_W + 1;

  typedef enum logic [1:0] {S_IDLE, S_PLAN, S_ADDR, S_DATA} state_t;

  state_t               state;
  logic [LEN_W-1:0]     len_q;
  logic [AXI_LEN_W-1:0] ar_len_q;
  logic                 last_burst_q;
  logic [CREDIT_W-1:0]  credits_avail;
  logic [CNT_W-1:0]     beats_resv;   // Beats reserved so far in this request
  logic [CNT_W-1:0]     words_total;
  logic [CREDIT_W-1:0]  refund_cnt;
  logic [CREDIT_W-1:0]  credit_add;
  logic [CREDIT_W-1:0]  credit_sub;
  logic [ADDR_W-1:0]    burst_addr;
  logic [BEAT_W-1:0]    burst_beats;
  logic                 is_last_burst;
  logic                 align_empty;
  logic                 issue;
  logic                 ar_fire;
  logic                 beat_fire;
  logic                 burst_done;

  assign req_accept = (state == S_IDLE) && req_valid && align_empty;
  assign issue      = (state == S_PLAN) && (credits_avail >= CREDIT_W'(burst_beats));
  assign ar_fire    = ar_valid && ar_ready;
  assign r_ready    = (state == S_DATA);
  assign beat_fire  = r_valid && r_ready;
  assign burst_done = beat_fire && r.last;

  // Every beat but the first yields a word, so only the final burst can
  // leave one reserved credit unused
  assign words_total = (CNT_W'(len_q) + CNT_W'(BYTES - 1)) >> OFF_W;
  assign refund_cnt  = (beats_resv > words_total) ?
                       CREDIT_W'(beats_resv - words_total) : '0;

  always_comb begin
    credit_add = CREDIT_W'(credit_return);
    if (burst_done) begin
      credit_add = credit_add + refund_cnt;
    end
    credit_sub = issue ? CREDIT_W'(burst_beats) : '0;
  end

  always_comb begin
    ar.addr  = burst_addr;
    ar.len   = ar_len_q;
    ar.size  = axi_size_of(DATA_W);
    ar.burst = AXI_BURST_INCR;
    ar.cache = AXI_CACHE_BUFFERABLE;
    ar.prot  = AXI_PROT_DATA;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state         <= S_IDLE;
      ar_valid      <= 1'b0;
      last_burst_q  <= 1'b0;
      credits_avail <= '0;
      beats_resv    <= '0;
    end else begin
      credits_avail <= credits_avail + credit_add - credit_sub;
      case (state)
        S_IDLE: begin
          if (req_accept) begin
            state      <= S_PLAN;
            beats_resv <= '0;
          end
        end
        S_PLAN: begin // Wait here until the whole burst is covered
          if (issue) begin
            state        <= S_ADDR;
            ar_valid     <= 1'b1;
            last_burst_q <= is_last_burst;
            beats_resv   <= beats_resv + CNT_W'(burst_beats);
          end
        end
        S_ADDR: begin
          if (ar_ready) begin
            ar_valid <= 1'b0;
            state    <= S_DATA;
          end
        end
        S_DATA: begin
          if (burst_done) begin
            state <= last_burst_q ? S_IDLE : S_PLAN;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_accept) begin
      len_q <= req.len_bytes;
    end
    if (issue) begin
      ar_len_q <= AXI_LEN_W'(burst_beats - BEAT_W'(1));
    end
  end

  burst_planner #(
    .ADDR_W    (ADDR_W),
    .DATA_W    (DATA_W),
    .LEN_W     (LEN_W),
    .MAX_BEATS (MAX_BEATS)
  ) planner_i (
    .clk            (clk),
    .rst            (rst),
    .transfer_start (req_accept),
    .addr           (req.addr),
    .len_bytes      (req.len_bytes),
    .burst_start    (ar_fire),
    .burst_addr     (burst_addr),
    .burst_beats    (burst_beats),
    .is_last_burst  (is_last_burst)
  );

  burst_align #(
    .DATA_W (DATA_W),
    .LEN_W  (LEN_W)
  ) align_i (
    .clk           (clk),
    .rst           (rst),
    .start         (req_accept),
    .offset        (req.addr[OFF_W-1:0]),
    .len_bytes     (req.len_bytes),
    .beat_data     (r.data),
    .beat_valid    (beat_fire),
    .beat_last     (r.last),
    .transfer_last (last_burst_q),
    .word          (out),
    .word_valid    (out_valid),
    .empty         (align_empty)
  );

endmodule

// File: logic/burst_align.sv
module burst_align
  import dma_pkg::*;
#(
  parameter int DATA_W = 32,
  parameter int LEN_W  = 12
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic [offset_w_of(DATA_W)-1:0] offset,
  input  logic [LEN_W-1:0]               len_bytes,
  input  logic [DATA_W-1:0]              beat_data,
  input  logic                           beat_valid,
  input  logic                           beat_last,
  input  logic                           transfer_last,
  output dma_word_t                      word,
  output logic                           word_valid,
  output logic                           empty
);

  localparam int OFF_W = offset_w_of(DATA_W);
  localparam int BYTES = DATA_W / 8;
  localparam int SH_W  = OFF_W + 4;
  localparam int WL_W  = LEN_W + 1;

  logic [OFF_W-1:0]  off_q;
  logic [DATA_W-1:0] held;       // Upper bytes of the previous beat, moved down
  logic              first_q;
  logic              flush_q;
  logic [WL_W-1:0]   words_left;
  logic [OFF_W+2:0]  lo_shift;
  logic [SH_W-1:0]   hi_shift;
  logic [DATA_W-1:0] joined;
  logic              emit_beat;

  assign lo_shift = {off_q, 3'b000};
  // Full width shift when aligned, so nothing of the new beat is added
  assign hi_shift = SH_W'(DATA_W) - SH_W'(lo_shift);
  assign joined   = held | (beat_data << hi_shift);

  // First beat only carries lead-in and the start of word 0
  assign emit_beat = beat_valid && !first_q && (words_left != '0);
  assign empty     = (words_left == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      first_q    <= 1'b0;
      flush_q    <= 1'b0;
      words_left <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (start) begin
        first_q    <= 1'b1;
        flush_q    <= 1'b0;
        words_left <= (WL_W'(len_bytes) + WL_W'(BYTES - 1)) >> OFF_W;
      end else begin
        if (beat_valid) begin
          first_q <= 1'b0;
        end
        flush_q <= beat_valid && beat_last && transfer_last;
        if (emit_beat) begin
          word_valid <= 1'b1;
          words_left <= words_left - 1'b1;
        end
        // Held bytes become the final word if still owed
        if (flush_q && (words_left != '0)) begin
          word_valid <= 1'b1;
          words_left <= words_left - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      off_q <= offset;
    end
    if (beat_valid) begin
      held <= beat_data >> lo_shift;
    end
    if (emit_beat) begin
      word.data <= joined;
      word.last <= (words_left == WL_W'(1));
    end else if (flush_q) begin
      word.data <= held; // Bytes past the length are don't-care
      word.last <= (words_left == WL_W'(1));
    end
  end

endmodule

// File: logic/burst_planner.sv
module burst_planner
  import axi_pkg::*, dma_pkg::*;
#(
  parameter int ADDR_W    = 32,
  parameter int DATA_W    = 32,
  parameter int LEN_W     = 12,
  parameter int MAX_BEATS = 16
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            transfer_start,
  input  logic [ADDR_W-1:0]               addr,
  input  logic [LEN_W-1:0]                len_bytes,
  input  logic                            burst_start,
  output logic [ADDR_W-1:0]               burst_addr,
  output logic [beat_w_of(MAX_BEATS)-1:0] burst_beats,
  output logic                            is_last_burst
);

  localparam int OFF_W  = offset_w_of(DATA_W);
  localparam int BYTES  = DATA_W / 8;
  localparam int BEAT_W = beat_w_of(MAX_BEATS);
  localparam int BND_W  = $clog2(AXI_BOUNDARY_BYTES);
  localparam int CNT_W  = ((LEN_W > BND_W) ? LEN_W : BND_W) + 2;

  logic [ADDR_W-1:0] cur_addr;   // Always beat aligned
  logic [CNT_W-1:0]  remain;     // Bytes left, counted from cur_addr
  logic [CNT_W-1:0]  beats_left;
  logic [CNT_W-1:0]  beats_to_bnd;
  logic [CNT_W-1:0]  beats_cap;
  logic [CNT_W-1:0]  burst_bytes;

  always_comb begin
    beats_left   = (remain + CNT_W'(BYTES - 1)) >> OFF_W;
    beats_to_bnd = (CNT_W'(AXI_BOUNDARY_BYTES) - CNT_W'(cur_addr[BND_W-1:0])) >> OFF_W;

    // Smallest of the three limits
    beats_cap = CNT_W'(MAX_BEATS);
    if (beats_to_bnd < beats_cap) begin
      beats_cap = beats_to_bnd;
    end
    if (beats_left < beats_cap) begin
      beats_cap = beats_left;
    end

    burst_bytes = beats_cap << OFF_W;
  end

  assign burst_addr    = cur_addr;
  assign burst_beats   = BEAT_W'(beats_cap);
  assign is_last_burst = (beats_left <= beats_cap);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cur_addr <= '0;
      remain   <= '0;
    end else if (transfer_start) begin
      // Lead-in bytes below the start address are fetched too
      cur_addr <= {addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
      remain   <= CNT_W'(len_bytes) + CNT_W'(addr[OFF_W-1:0]);
    end else if (burst_start) begin
      cur_addr <= cur_addr + ADDR_W'(burst_bytes);
      remain   <= (remain > burst_bytes) ? remain - burst_bytes : '0; // Tail may overshoot
    end
  end

endmodule

// File: logic/dma_pkg.sv
package dma_pkg;

  localparam int DMA_ADDR_W = 32;
  localparam int DMA_DATA_W = 32;
  localparam int DMA_LEN_W  = 12;

  typedef struct packed {
    logic [DMA_ADDR_W-1:0] addr;
    logic [DMA_LEN_W-1:0]  len_bytes;
  } dma_req_t;

  typedef struct packed {
    logic [DMA_DATA_W-1:0] data;
    logic                  last; // Final word of the request
  } dma_word_t;

  function automatic int offset_w_of(input int data_w);
    return $clog2(data_w / 8);
  endfunction

  // Enough bits to hold max_beats itself
  function automatic int beat_w_of(input int max_beats);
    return $clog2(max_beats + 1);
  endfunction

endpackage

// File: logic/axi_pkg.sv
package axi_pkg;

  localparam int AXI_ADDR_W  = 32;
  localparam int AXI_DATA_W  = 32;
  localparam int AXI_LEN_W   = 8;
  localparam int AXI_SIZE_W  = 3;
  localparam int AXI_BURST_W = 2;
  localparam int AXI_CACHE_W = 4;
  localparam int AXI_PROT_W  = 3;

  localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR       = 2'b01;
  localparam logic [AXI_CACHE_W-1:0] AXI_CACHE_BUFFERABLE = 4'b0001;
  localparam logic [AXI_PROT_W-1:0]  AXI_PROT_DATA        = 3'b010; // Unprivileged, non-secure

  // Bursts may not cross this
  localparam int AXI_BOUNDARY_BYTES = 4096;

  // Read address channel
  typedef struct packed {
    logic [AXI_ADDR_W-1:0]  addr;
    logic [AXI_LEN_W-1:0]   len;
    logic [AXI_SIZE_W-1:0]  size;
    logic [AXI_BURST_W-1:0] burst;
    logic [AXI_CACHE_W-1:0] cache;
    logic [AXI_PROT_W-1:0]  prot;
  } axi_ar_t;

  // Read data channel
  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic                  last;
  } axi_r_t;

  // Full-width transfer size code
  function automatic logic [AXI_SIZE_W-1:0] axi_size_of(input int data_w);
    return AXI_SIZE_W'($clog2(data_w / 8));
  endfunction

endpackage
